//--- hdl/decode_stage.sv
// Decode stage
// Control decode, immediate build, interlock against older writers,
// and the ID/EX register
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  logic              clk,
    input  logic              reset,
    input  logic              interrupt,
    input  logic              redirect,
    input  isa_pkg::instr_u   if_id_instr,
    input  isa_pkg::word_t    if_id_pc,
    input  logic              if_id_valid,
    input  pipe_pkg::ex_mem_t ex_mem,
    input  pipe_pkg::retire_t wb,
    output pipe_pkg::id_ex_t  id_ex,
    output logic              stall
);

    isa_pkg::reg_idx_t rs1;
    isa_pkg::reg_idx_t rs2;
    isa_pkg::word_t    rs1_data;
    isa_pkg::word_t    rs2_data;
    logic [2:0]        funct3;
    logic              f3_ok;      // funct3 is one of the kept ALU forms
    logic              uses_rs1;
    logic              uses_rs2;
    pipe_pkg::id_ex_t  dec;

    assign rs1    = if_id_instr.r_fmt.rs1;
    assign rs2    = if_id_instr.r_fmt.rs2;
    assign funct3 = if_id_instr.r_fmt.funct3;
    assign f3_ok  = funct3 inside {isa_pkg::F3_ADD, isa_pkg::F3_AND,
                                   isa_pkg::F3_OR, isa_pkg::F3_XOR};

    reg_file u_reg_file (
        .clk      (clk),
        .reset    (reset),
        .rs1      (rs1),
        .rs2      (rs2),
        .wb       (wb),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    // Same funct3 map for register and immediate ALU forms
    function automatic pipe_pkg::alu_op_e f3_op(input logic [2:0] f3);
        case (f3)
            isa_pkg::F3_AND: return pipe_pkg::ALU_AND;
            isa_pkg::F3_OR:  return pipe_pkg::ALU_OR;
            isa_pkg::F3_XOR: return pipe_pkg::ALU_XOR;
            default:         return pipe_pkg::ALU_ADD;
        endcase
    endfunction

    always_comb begin
        dec          = '0;
        dec.valid    = if_id_valid;
        dec.pc       = if_id_pc;
        dec.rd       = if_id_instr.r_fmt.rd;
        dec.rs1_data = rs1_data;
        dec.rs2_data = rs2_data;
        dec.alu_op   = pipe_pkg::ALU_ADD; // Address add for LW and SW
        uses_rs1     = 1'b0;
        uses_rs2     = 1'b0;
        case (if_id_instr.r_fmt.opcode)
            isa_pkg::OP_REG: begin
                uses_rs1      = 1'b1;
                uses_rs2      = 1'b1;
                dec.reg_write = f3_ok;    // Other funct3 retires as no-op
                if (funct3 == isa_pkg::F3_ADD &&
                    if_id_instr.r_fmt.funct7 == isa_pkg::F7_SUB) begin
                    dec.alu_op = pipe_pkg::ALU_SUB;
                end else begin
                    dec.alu_op = f3_op(funct3);
                end
            end
            isa_pkg::OP_IMM: begin
                uses_rs1      = 1'b1;
                dec.reg_write = f3_ok;
                dec.use_imm   = 1'b1;
                dec.alu_op    = f3_op(funct3);
                dec.immediate = {{20{if_id_instr.i_fmt.imm[11]}}, if_id_instr.i_fmt.imm};
            end
            isa_pkg::OP_LUI: begin
                dec.reg_write = 1'b1;
                dec.use_imm   = 1'b1;
                dec.alu_op    = pipe_pkg::ALU_PASS_B;
                dec.immediate = {if_id_instr.u_fmt.imm, 12'b0};
            end
            isa_pkg::OP_LOAD: begin
                uses_rs1      = 1'b1;
                dec.reg_write = (funct3 == isa_pkg::F3_LW_SW);
                dec.mem_read  = (funct3 == isa_pkg::F3_LW_SW);
                dec.use_imm   = 1'b1;
                dec.immediate = {{20{if_id_instr.i_fmt.imm[11]}}, if_id_instr.i_fmt.imm};
            end
            isa_pkg::OP_STORE: begin
                uses_rs1      = 1'b1;
                uses_rs2      = 1'b1;     // Store data
                dec.mem_write = (funct3 == isa_pkg::F3_LW_SW);
                dec.use_imm   = 1'b1;
                dec.immediate = {{20{if_id_instr.s_fmt.imm_hi[6]}},
                                 if_id_instr.s_fmt.imm_hi, if_id_instr.s_fmt.imm_lo};
            end
            isa_pkg::OP_BRANCH: begin
                uses_rs1      = 1'b1;
                uses_rs2      = 1'b1;
                dec.branch    = (funct3 == isa_pkg::F3_BEQ);
                dec.immediate = {{19{if_id_instr.b_fmt.imm12}}, if_id_instr.b_fmt.imm12,
                                 if_id_instr.b_fmt.imm11, if_id_instr.b_fmt.imm10_5,
                                 if_id_instr.b_fmt.imm4_1, 1'b0};
            end
            isa_pkg::OP_JAL: begin
                dec.reg_write = 1'b1;     // Link pc+4
                dec.jump      = 1'b1;
                dec.immediate = {{11{if_id_instr.j_fmt.imm20}}, if_id_instr.j_fmt.imm20,
                                 if_id_instr.j_fmt.imm19_12, if_id_instr.j_fmt.imm11,
                                 if_id_instr.j_fmt.imm10_1, 1'b0};
            end
            default: ;                    // No-op that writes nothing
        endcase
    end

    // True if an older valid instruction still has to write r
    function automatic logic pending(input isa_pkg::reg_idx_t r);
        return (r != '0) &&
               ((id_ex.valid  && id_ex.reg_write  && id_ex.rd  == r) ||
                (ex_mem.valid && ex_mem.reg_write && ex_mem.rd == r) ||
                (wb.valid     && wb.reg_write     && wb.rd     == r));
    endfunction

    always_comb begin
        stall = if_id_valid && ((uses_rs1 && pending(rs1)) || (uses_rs2 && pending(rs2)));
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            id_ex <= '0;
        end else if (interrupt || redirect || stall || !if_id_valid) begin
            id_ex <= '0;                  // Bubble
        end else begin
            id_ex <= dec;
        end
    end

endmodule

`default_nettype wire

//--- hdl/execute_stage.sv
// Execute stage
// ALU, BEQ and JAL resolution, and the EX/MEM register
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  logic              clk,
    input  logic              reset,
    input  pipe_pkg::id_ex_t  id_ex,
    output pipe_pkg::ex_mem_t ex_mem,
    output logic              redirect,
    output isa_pkg::word_t    redirect_pc
);

    isa_pkg::word_t op_b;
    isa_pkg::word_t alu_result;

    assign op_b = id_ex.use_imm ? id_ex.immediate : id_ex.rs2_data;

    always_comb begin
        case (id_ex.alu_op)
            pipe_pkg::ALU_SUB:    alu_result = id_ex.rs1_data - op_b;
            pipe_pkg::ALU_AND:    alu_result = id_ex.rs1_data & op_b;
            pipe_pkg::ALU_OR:     alu_result = id_ex.rs1_data | op_b;
            pipe_pkg::ALU_XOR:    alu_result = id_ex.rs1_data ^ op_b;
            pipe_pkg::ALU_PASS_B: alu_result = op_b;          // LUI
            default:              alu_result = id_ex.rs1_data + op_b;
        endcase
    end

    // Taken BEQ or any JAL jumps pc-relative
    assign redirect = id_ex.valid &&
                      (id_ex.jump || (id_ex.branch && id_ex.rs1_data == id_ex.rs2_data));
    assign redirect_pc = id_ex.pc + id_ex.immediate;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ex_mem <= '0;
        end else begin
            ex_mem.valid      <= id_ex.valid;
            ex_mem.pc         <= id_ex.pc;
            ex_mem.rd         <= id_ex.rd;
            ex_mem.alu_result <= id_ex.jump ? id_ex.pc + 32'd4 : alu_result; // JAL link
            ex_mem.store_data <= id_ex.rs2_data;
            ex_mem.reg_write  <= id_ex.reg_write;
            ex_mem.mem_read   <= id_ex.mem_read;
            ex_mem.mem_write  <= id_ex.mem_write;
        end
    end

endmodule

`default_nettype wire

//--- hdl/fetch_stage.sv
// Fetch stage
// Program counter, next-PC choice and the IF/ID register
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
    input  logic            clk,
    input  logic            reset,
    input  logic            interrupt,
    input  logic            stall,
    input  logic            redirect,
    input  isa_pkg::word_t  redirect_pc,
    input  isa_pkg::word_t  imem_data,
    output isa_pkg::word_t  imem_addr,
    output isa_pkg::instr_u if_id_instr,
    output isa_pkg::word_t  if_id_pc,
    output logic            if_id_valid
);

    isa_pkg::word_t pc;
    isa_pkg::word_t next_pc;

    assign imem_addr = pc; // Instruction returns in the same cycle

    // Interrupt wins over redirect, redirect over stall
    always_comb begin
        if (interrupt) begin
            next_pc = pipe_pkg::INT_VECTOR;
        end else if (redirect) begin
            next_pc = redirect_pc;
        end else if (stall) begin
            next_pc = pc;           // Hold
        end else begin
            next_pc = pc + 32'd4;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= '0;
        end else begin
            pc <= next_pc;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            if_id_instr <= isa_pkg::NOP_INSTR;
            if_id_pc    <= '0;
            if_id_valid <= 1'b0;
        end else if (interrupt || redirect) begin
            if_id_instr <= isa_pkg::NOP_INSTR; // Squash wrong-path fetch
            if_id_valid <= 1'b0;
        end else if (!stall) begin
            if_id_instr <= imem_data;
            if_id_pc    <= pc;
            if_id_valid <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- hdl/isa_pkg.sv
// RV32I subset ISA definitions
// Widths, major opcodes, funct codes and the instruction format views
`default_nettype none

package isa_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_idx_t;

    // Major opcodes
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;

    localparam logic [2:0] F3_ADD   = 3'b000; // ADD, SUB, ADDI
    localparam logic [2:0] F3_XOR   = 3'b100;
    localparam logic [2:0] F3_OR    = 3'b110;
    localparam logic [2:0] F3_AND   = 3'b111;
    localparam logic [2:0] F3_LW_SW = 3'b010; // Word access
    localparam logic [2:0] F3_BEQ   = 3'b000;
    localparam logic [6:0] F7_SUB   = 7'b0100000;

    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_idx_t    rs1;
        logic [2:0]  funct3;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    // Scattered branch offset bits with bit 0 implied zero
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm; // Upper 20 bits
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // One instruction word read through whichever format the opcode names
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } instr_u;

    localparam word_t NOP_INSTR = 32'h0000_0013; // ADDI x0, x0, 0

endpackage

`default_nettype wire

//--- hdl/mem_wb_stage.sv
// Memory and write-back stages
// Word data memory, MEM/WB register and the retire bundle
`timescale 1ns/1ps
`default_nettype none

module mem_wb_stage (
    input  logic              clk,
    input  logic              reset,
    input  pipe_pkg::ex_mem_t ex_mem,
    output pipe_pkg::retire_t wb
);

    isa_pkg::word_t                  dmem [pipe_pkg::DMEM_WORDS];
    logic [pipe_pkg::DMEM_IDX_W-1:0] idx;
    isa_pkg::word_t                  load_data;
    pipe_pkg::mem_wb_t               mem_wb;

    assign idx       = ex_mem.alu_result[pipe_pkg::DMEM_IDX_W+1:2]; // Wraps past 1 KiB
    assign load_data = dmem[idx];                                    // Combinational read

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < pipe_pkg::DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (ex_mem.valid && ex_mem.mem_write) begin
            dmem[idx] <= ex_mem.store_data;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mem_wb <= '0;
        end else begin
            mem_wb.valid     <= ex_mem.valid;
            mem_wb.pc        <= ex_mem.pc;
            mem_wb.rd        <= ex_mem.rd;
            mem_wb.reg_write <= ex_mem.reg_write;
            // Select by this instruction's own load flag
            mem_wb.wb_data   <= ex_mem.mem_read ? load_data : ex_mem.alu_result;
        end
    end

    always_comb begin
        wb.valid     = mem_wb.valid;
        wb.pc        = mem_wb.pc;
        wb.rd        = mem_wb.rd;
        wb.reg_write = mem_wb.reg_write;
        wb.data      = mem_wb.wb_data;
    end

endmodule

`default_nettype wire

//--- hdl/pipe_pkg.sv
// Pipeline definitions for the five-stage core
// ALU operations, stage register bundles and the retire report
`default_nettype none

package pipe_pkg;

    localparam isa_pkg::word_t INT_VECTOR = 32'h0000_1000; // Interrupt target
    localparam int DMEM_WORDS = 256;
    localparam int DMEM_IDX_W = $clog2(DMEM_WORDS);        // Address bits 9:2

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS_B  // LUI
    } alu_op_e;

    typedef struct packed {
        logic              valid;
        isa_pkg::word_t    pc;
        isa_pkg::reg_idx_t rd;
        isa_pkg::word_t    rs1_data;
        isa_pkg::word_t    rs2_data;
        isa_pkg::word_t    immediate;
        alu_op_e           alu_op;
        logic              use_imm;   // Operand B from immediate
        logic              reg_write;
        logic              mem_read;
        logic              mem_write;
        logic              branch;    // BEQ
        logic              jump;      // JAL
    } id_ex_t;

    typedef struct packed {
        logic              valid;
        isa_pkg::word_t    pc;
        isa_pkg::reg_idx_t rd;
        isa_pkg::word_t    alu_result; // Also the memory address
        isa_pkg::word_t    store_data;
        logic              reg_write;
        logic              mem_read;
        logic              mem_write;
    } ex_mem_t;

    typedef struct packed {
        logic              valid;
        isa_pkg::word_t    pc;
        isa_pkg::reg_idx_t rd;
        logic              reg_write;
        isa_pkg::word_t    wb_data;
    } mem_wb_t;

    // Retire report that doubles as the register file write port
    typedef struct packed {
        logic              valid;
        isa_pkg::word_t    pc;
        isa_pkg::reg_idx_t rd;
        logic              reg_write;
        isa_pkg::word_t    data;
    } retire_t;

endpackage

`default_nettype wire

//--- hdl/reg_file.sv
// Register file, 32 x 32 bits
// x0 reads zero; a same-cycle write is returned on a matching read
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic               clk,
    input  logic               reset,
    input  isa_pkg::reg_idx_t  rs1,
    input  isa_pkg::reg_idx_t  rs2,
    input  pipe_pkg::retire_t  wb,
    output isa_pkg::word_t     rs1_data,
    output isa_pkg::word_t     rs2_data
);

    isa_pkg::word_t regs [2**isa_pkg::REG_ADDR_W];
    logic           wr_en;

    assign wr_en = wb.valid && wb.reg_write && (wb.rd != '0);

    function automatic isa_pkg::word_t read_port(input isa_pkg::reg_idx_t idx);
        if (idx == '0) begin
            return '0;
        end
        if (wr_en && (wb.rd == idx)) begin
            return wb.data;    // Write-through
        end
        return regs[idx];
    endfunction

    always_comb rs1_data = read_port(rs1);
    always_comb rs2_data = read_port(rs2);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 2**isa_pkg::REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb.rd] <= wb.data;
        end
    end

endmodule

`default_nettype wire

//--- hdl/rv_core.sv
// Five-stage in-order RV32I subset core
// Instruction fetch port in, retire report and stall/flush levels out
`timescale 1ns/1ps
`default_nettype none

module rv_core (
    input  logic              clk,
    input  logic              reset,
    input  logic              interrupt,
    input  isa_pkg::word_t    imem_data,
    output isa_pkg::word_t    imem_addr,
    output pipe_pkg::retire_t retire,
    output logic              stall,
    output logic              flush
);

    isa_pkg::instr_u   if_id_instr;
    isa_pkg::word_t    if_id_pc;
    logic              if_id_valid;
    pipe_pkg::id_ex_t  id_ex;
    pipe_pkg::ex_mem_t ex_mem;
    logic              redirect;
    isa_pkg::word_t    redirect_pc;

    assign flush = interrupt || redirect; // Either one squashes IF/ID and ID/EX

    fetch_stage u_fetch (
        .clk         (clk),
        .reset       (reset),
        .interrupt   (interrupt),
        .stall       (stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .imem_data   (imem_data),
        .imem_addr   (imem_addr),
        .if_id_instr (if_id_instr),
        .if_id_pc    (if_id_pc),
        .if_id_valid (if_id_valid)
    );

    decode_stage u_decode (
        .clk         (clk),
        .reset       (reset),
        .interrupt   (interrupt),
        .redirect    (redirect),
        .if_id_instr (if_id_instr),
        .if_id_pc    (if_id_pc),
        .if_id_valid (if_id_valid),
        .ex_mem      (ex_mem),
        .wb          (retire),      // Write-back feeds the register file
        .id_ex       (id_ex),
        .stall       (stall)
    );

    execute_stage u_execute (
        .clk         (clk),
        .reset       (reset),
        .id_ex       (id_ex),
        .ex_mem      (ex_mem),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    mem_wb_stage u_mem_wb (
        .clk    (clk),
        .reset  (reset),
        .ex_mem (ex_mem),
        .wb     (retire)
    );

endmodule

`default_nettype wire

//--- sim.f
hdl/isa_pkg.sv
hdl/pipe_pkg.sv
hdl/fetch_stage.sv
hdl/reg_file.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/mem_wb_stage.sv
hdl/rv_core.sv
sim/tb_core.sv

//--- sim/tb_core.sv
// Testbench for the five-stage core
// Runs a random program from a fixed seed and checks every retire report
// against an instruction-level model that steps once per retire
`timescale 1ns/1ps
`default_nettype none

module tb_core;

    localparam int MAIN_LEN    = 200;   // Main block at address 0
    localparam int HANDLER_LEN = 8;     // Handler block at the interrupt vector
    localparam int NUM_RETIRES = 1200;
    localparam int RUN_LIMIT   = 20000; // Cycles

    logic              clk;
    logic              reset;
    logic              interrupt;
    isa_pkg::word_t    imem_data;
    isa_pkg::word_t    imem_addr;
    pipe_pkg::retire_t retire;
    logic              stall;
    logic              flush;

    isa_pkg::word_t imem [isa_pkg::word_t];      // Program image by byte address
    bit             lu_reader [isa_pkg::word_t]; // Readers placed right after a LW
    logic           prog_ready = 1'b0;

    // Reference model state
    isa_pkg::word_t regs [32];
    isa_pkg::word_t mem [pipe_pkg::DMEM_WORDS];
    isa_pkg::word_t exp_pc      = '0;
    isa_pkg::word_t last_pc     = '1;            // No retire yet
    logic           irq_pending = 1'b0;
    logic           started     = 1'b0;          // First retire seen
    int             value_errors = 0;
    int             other_errors = 0;
    int             retired      = 0;
    int             cycles       = 0;            // Cycles since reset release
    int             stall_total  = 0;
    int             stall_at_last     = 0;
    int             stall_before_last = 0;

    rv_core DUT (
        .clk       (clk),
        .reset     (reset),
        .interrupt (interrupt),
        .imem_data (imem_data),
        .imem_addr (imem_addr),
        .retire    (retire),
        .stall     (stall),
        .flush     (flush)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic isa_pkg::word_t fetch_word(input isa_pkg::word_t addr);
        if (imem.exists(addr)) begin
            return imem[addr];
        end
        return isa_pkg::NOP_INSTR;               // Outside the program
    endfunction

    always @(imem_addr, prog_ready) begin
        imem_data = prog_ready ? fetch_word(imem_addr) : isa_pkg::NOP_INSTR;
    end

    // Instruction encoders, straight from the RV32I formats
    function automatic isa_pkg::word_t r_type(input logic [6:0] f7, input isa_pkg::reg_idx_t rs2,
                                              input isa_pkg::reg_idx_t rs1, input logic [2:0] f3,
                                              input isa_pkg::reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, isa_pkg::OP_REG};
    endfunction

    function automatic isa_pkg::word_t i_type(input logic [6:0] op, input logic [11:0] imm,
                                              input isa_pkg::reg_idx_t rs1, input logic [2:0] f3,
                                              input isa_pkg::reg_idx_t rd);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic isa_pkg::word_t s_type(input logic [11:0] imm, input isa_pkg::reg_idx_t rs2,
                                              input isa_pkg::reg_idx_t rs1);
        return {imm[11:5], rs2, rs1, isa_pkg::F3_LW_SW, imm[4:0], isa_pkg::OP_STORE};
    endfunction

    function automatic isa_pkg::word_t b_type(input logic [12:0] imm, input isa_pkg::reg_idx_t rs2,
                                              input isa_pkg::reg_idx_t rs1);
        return {imm[12], imm[10:5], rs2, rs1, isa_pkg::F3_BEQ, imm[4:1], imm[11],
                isa_pkg::OP_BRANCH};
    endfunction

    function automatic isa_pkg::word_t j_type(input logic [20:0] imm, input isa_pkg::reg_idx_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, isa_pkg::OP_JAL};
    endfunction

    function automatic logic [2:0] pick_f3();
        case ($urandom_range(0, 3))
            0:       return isa_pkg::F3_ADD;
            1:       return isa_pkg::F3_AND;
            2:       return isa_pkg::F3_OR;
            default: return isa_pkg::F3_XOR;
        endcase
    endfunction

    // Word address wraps modulo the data memory depth
    function automatic int word_index(input isa_pkg::word_t addr);
        return (addr >> 2) % pipe_pkg::DMEM_WORDS;
    endfunction

    // Random code block on the x1 memory base that ends in a jump to 0
    task automatic build_block(input isa_pkg::word_t base, input int len, input bit with_flow);
        int                i;
        int                kind;
        int                k;
        int                off;
        logic [2:0]        f3;
        logic [6:0]        f7;
        isa_pkg::reg_idx_t rd;
        isa_pkg::reg_idx_t ra;
        isa_pkg::reg_idx_t rb;
        isa_pkg::word_t    at;
        imem[base] = i_type(isa_pkg::OP_IMM, 12'(4 * $urandom_range(0, 255)), 5'd0,
                            isa_pkg::F3_ADD, 5'd1);
        i = 1;
        while (i < len - 1) begin
            at   = base + 4 * i;
            kind = $urandom_range(0, 99);
            rd   = 5'(2 + $urandom_range(0, 13));  // Never x0 or the base
            ra   = 5'($urandom_range(0, 15));
            rb   = 5'($urandom_range(0, 15));
            off  = 4 * $urandom_range(0, 511) - 1024; // Crosses the wrap both ways
            f3   = pick_f3();
            f7   = (f3 == isa_pkg::F3_ADD && $urandom_range(0, 1) == 1) ? isa_pkg::F7_SUB : 7'd0;
            if (kind < 25) begin
                imem[at] = r_type(f7, rb, ra, f3, rd);
            end else if (kind < 45) begin
                imem[at] = i_type(isa_pkg::OP_IMM, 12'($urandom), ra, f3, rd);
            end else if (kind < 50) begin
                imem[at] = {20'($urandom), rd, isa_pkg::OP_LUI};
            end else if (kind < 60) begin
                imem[at] = i_type(isa_pkg::OP_LOAD, off[11:0], 5'd1, isa_pkg::F3_LW_SW, rd);
            end else if (kind < 70) begin
                imem[at] = s_type(off[11:0], rb, 5'd1);
            end else if (kind < 74) begin
                imem[at] = i_type(isa_pkg::OP_IMM, 12'(4 * $urandom_range(0, 255)), 5'd0,
                                  isa_pkg::F3_ADD, 5'd1);       // New base
            end else if (kind < 84 && i < len - 2) begin
                // LW then an immediate reader of its rd
                imem[at]     = i_type(isa_pkg::OP_LOAD, off[11:0], 5'd1, isa_pkg::F3_LW_SW, rd);
                imem[at + 4] = r_type(7'd0, rb, rd, isa_pkg::F3_ADD, 5'(2 + $urandom_range(0, 13)));
                lu_reader[at + 4] = 1'b1;
                i++;
            end else if (with_flow) begin
                k = $urandom_range(1, 6);
                if (i + k > len - 1) begin
                    k = len - 1 - i;                    // Forward and inside the block
                end
                if (kind < 92) begin
                    imem[at] = b_type(13'(4 * k), ($urandom_range(0, 1) == 1) ? ra : rb, ra);
                end else begin
                    imem[at] = j_type(21'(4 * k), rd);
                end
            end else begin
                imem[at] = i_type(isa_pkg::OP_IMM, 12'($urandom), ra, f3, rd);
            end
            i++;
        end
        imem[base + 4 * (len - 1)] = j_type(21'(-(base + 4 * (len - 1))), 5'd0); // Restart main
    endtask

    task automatic compare_word(input string name, input isa_pkg::word_t exp,
                                input isa_pkg::word_t act);
        assert (act == exp) else begin
            value_errors++;
            $display("** Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // Step the model by one instruction and compare with the retire report
    task automatic retire_step();
        isa_pkg::word_t w;
        isa_pkg::word_t a;
        isa_pkg::word_t b;
        isa_pkg::word_t imm;
        isa_pkg::word_t res;
        isa_pkg::word_t nxt;
        logic           we;
        string          name;
        if (!started) begin
            compare_word("first retire latency", 32'd4, cycles);
        end
        started = 1'b1;
        // Interrupt entry is the only allowed break in program order
        if (retire.pc != exp_pc && irq_pending && retire.pc == pipe_pkg::INT_VECTOR) begin
            exp_pc = pipe_pkg::INT_VECTOR;
        end
        if (retire.pc == pipe_pkg::INT_VECTOR) begin
            irq_pending = 1'b0;
        end
        w    = fetch_word(exp_pc);
        a    = regs[w[19:15]];
        b    = regs[w[24:20]];
        imm  = {{20{w[31]}}, w[31:20]};          // I-type immediate
        res  = '0;
        we   = 1'b0;
        nxt  = exp_pc + 4;
        name = "other";
        case (w[6:0])
            isa_pkg::OP_REG, isa_pkg::OP_IMM: begin
                name = (w[6:0] == isa_pkg::OP_REG) ? "alu_reg" : "alu_imm";
                if (w[6:0] == isa_pkg::OP_IMM) begin
                    b = imm;
                end
                we = 1'b1;
                case (w[14:12])
                    isa_pkg::F3_AND: res = a & b;
                    isa_pkg::F3_OR:  res = a | b;
                    isa_pkg::F3_XOR: res = a ^ b;
                    default: res = (w[6:0] == isa_pkg::OP_REG && w[31:25] == isa_pkg::F7_SUB) ?
                                   a - b : a + b;
                endcase
            end
            isa_pkg::OP_LUI: begin
                name = "lui";
                we   = 1'b1;
                res  = {w[31:12], 12'b0};
            end
            isa_pkg::OP_LOAD: begin
                name = "lw";
                we   = 1'b1;
                res  = mem[word_index(a + imm)];
            end
            isa_pkg::OP_STORE: begin
                name = "sw";
                mem[word_index(a + {{20{w[31]}}, w[31:25], w[11:7]})] = b;
            end
            isa_pkg::OP_BRANCH: begin
                name = "beq";
                if (a == b) begin
                    nxt = exp_pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                end
            end
            isa_pkg::OP_JAL: begin
                name = "jal";
                we   = 1'b1;
                res  = exp_pc + 4;                // Link
                nxt  = exp_pc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            end
            default: ;
        endcase
        compare_word({name, " pc"}, exp_pc, retire.pc);
        compare_word({name, " reg_write"}, 32'(we), 32'(retire.reg_write));
        if (we) begin
            compare_word({name, " rd"}, 32'(w[11:7]), 32'(retire.rd));
            compare_word({name, " data"}, res, retire.data);
            if (w[11:7] != 5'd0) begin
                regs[w[11:7]] = res;
            end
        end
        // Reader right behind its LW must have seen the interlock
        if (lu_reader.exists(retire.pc) && last_pc == retire.pc - 4) begin
            assert (stall_total > stall_before_last) else begin
                other_errors++;
                $display("Load-use reader at pc %h retired without any stall", retire.pc);
            end
        end
        stall_before_last = stall_at_last;
        stall_at_last     = stall_total;
        last_pc           = retire.pc;
        exp_pc            = nxt;
        retired++;
    endtask

    // Retire monitor on the falling edge
    initial begin
        forever begin
            @(negedge clk);
            if (reset) begin
                assert (!retire.valid && !stall && !flush) else begin
                    other_errors++;
                    $display("retire.valid, stall or flush is high during reset");
                end
            end else begin
                if (stall) begin
                    stall_total++;
                end
                assert (!interrupt || flush) else begin
                    other_errors++;
                    $display("flush is low in a cycle with interrupt high");
                end
                if (retire.valid) begin
                    retire_step();
                end
            end
        end
    end

    initial begin
        int gap;                                  // Cycles to the next interrupt
        void'($urandom(32'h3a2e));
        reset     = 1'b1;
        interrupt = 1'b0;
        foreach (regs[i]) begin
            regs[i] = '0;
        end
        foreach (mem[i]) begin
            mem[i] = '0;
        end
        build_block('0, MAIN_LEN, 1'b1);
        build_block(pipe_pkg::INT_VECTOR, HANDLER_LEN, 1'b0);
        prog_ready = 1'b1;
        gap = 20 + $urandom_range(0, 200);
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        while (retired < NUM_RETIRES && cycles < RUN_LIMIT) begin
            @(posedge clk);
            cycles++;
            interrupt <= 1'b0;                    // One-cycle pulses
            if (started) begin
                gap--;
                if (gap == 0) begin
                    interrupt   <= 1'b1;
                    irq_pending = 1'b1;
                    gap         = 20 + $urandom_range(0, 200);
                end
            end
        end
        assert (retired >= NUM_RETIRES) else begin
            other_errors++;
            $display("Timeout after %0d cycles, %0d of %0d instructions retired",
                     cycles, retired, NUM_RETIRES);
        end
        $display("Retired %0d instructions, %0d value errors, %0d other errors",
                 retired, value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
